// ==== common/maxnetPkg.sv ====
`default_nettype none

package maxnetPkg;

    // datapath widths
    localparam int XLEN        = 8;
    localparam int NUM_NEURONS = 4;
    localparam int IDX_W       = $clog2(NUM_NEURONS);

    // sum of the other three activations needs two extra bits
    localparam int SUM_W = XLEN + 2;

    // epsilon is 1/8, rounded up so every step makes progress
    localparam int EPS_SHIFT = 3;
    localparam int EPS_ROUND = (1 << EPS_SHIFT) - 1;

    // convergence takes at most MAX_VALUE steps
    localparam int MAX_VALUE = 255;
    localparam int ITER_W    = $clog2(MAX_VALUE + 1) + 1;

    // number of nonzero neurons, 0 to NUM_NEURONS
    localparam int LIVE_CNT_W = $clog2(NUM_NEURONS + 1);

    // input side credits, equal to the loader buffer depth
    localparam int IN_CREDITS = 4;
    localparam int BUF_PTR_W  = $clog2(IN_CREDITS);
    localparam int BUF_CNT_W  = $clog2(IN_CREDITS + 1);

    // result credits held by the DUT after reset
    localparam int OUT_CREDITS  = 2;
    localparam int OUT_CREDIT_W = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

// ==== hw/sampleLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleLoader import maxnetPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  logic [XLEN-1:0] inData,
    input  logic            loadStep,
    output logic            inCredit,
    output logic            bufferFull,
    output logic [XLEN-1:0] xVec [NUM_NEURONS]
);

    logic [XLEN-1:0]      wordBuf [IN_CREDITS];
    logic [BUF_PTR_W-1:0] wrPtr;
    logic [BUF_PTR_W-1:0] rdPtr;
    logic [BUF_CNT_W-1:0] count;
    logic [IDX_W-1:0]     readSlot;
    logic                 push;
    logic                 pop;

    // source only sends while it holds a credit, so no overflow check
    assign push = inValid;
    assign pop  = loadStep && (count != '0);

    assign bufferFull = (count == BUF_CNT_W'(IN_CREDITS));

    always_ff @(posedge clk) begin
        if (push) begin
            wordBuf[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back per word moved out of the buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            inCredit <= 1'b0;
        end else begin
            inCredit <= pop;
        end
    end

    // original vector, kept for reporting the winning value
    always_ff @(posedge clk) begin
        if (rst) begin
            readSlot <= '0;
            for (int i = 0; i < NUM_NEURONS; i++) begin
                xVec[i] <= '0;
            end
        end else if (pop) begin
            xVec[readSlot] <= wordBuf[rdPtr];
            readSlot       <= readSlot + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== maxnet/maxnetNeuron.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxnetNeuron import maxnetPkg::*; #(
    parameter int NEURON_INDEX = 0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            startVector,
    input  logic            iterate,
    input  logic [XLEN-1:0] xOwn,
    input  logic [XLEN-1:0] activations [NUM_NEURONS],
    output logic [XLEN-1:0] activation
);

    logic [SUM_W-1:0] othersSum;
    logic [SUM_W-1:0] inhibit;
    logic [XLEN-1:0]  updated;

    // lateral input from every other neuron
    always_comb begin
        othersSum = '0;
        for (int i = 0; i < NUM_NEURONS; i++) begin
            if (i != NEURON_INDEX) begin
                othersSum = othersSum + SUM_W'(activations[i]);
            end
        end
    end

    // ceil(sum / 8)
    assign inhibit = (othersSum + SUM_W'(EPS_ROUND)) >> EPS_SHIFT;

    // subtract and clamp at zero
    always_comb begin
        if (SUM_W'(activation) > inhibit) begin
            updated = activation - XLEN'(inhibit);
        end else begin
            updated = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            activation <= '0;
        end else if (startVector) begin
            activation <= xOwn;
        end else if (iterate) begin
            activation <= updated;
        end
    end

endmodule

`default_nettype wire

// ==== hw/winnerSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module winnerSelect import maxnetPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   activations [NUM_NEURONS],
    input  logic [XLEN-1:0]   xVec [NUM_NEURONS],
    input  logic [ITER_W-1:0] iterCount,
    input  logic              report,
    input  logic              outCredit,
    output logic              converged,
    output logic              resultSent,
    output logic              outValid,
    output logic [IDX_W-1:0]  outIndex,
    output logic [XLEN-1:0]   outValue,
    output logic              outTie,
    output logic [ITER_W-1:0] outIters
);

    logic [LIVE_CNT_W-1:0]   liveCount;
    logic [IDX_W-1:0]        winnerIdx;
    logic                    allZero;
    logic                    send;
    logic [OUT_CREDIT_W-1:0] creditCount;

    // count survivors; with a single survivor the last hit is the winner
    always_comb begin
        liveCount = '0;
        winnerIdx = '0;
        for (int i = 0; i < NUM_NEURONS; i++) begin
            if (activations[i] != '0) begin
                liveCount = liveCount + 1'b1;
                winnerIdx = IDX_W'(i);
            end
        end
    end

    assign allZero   = (liveCount == '0);
    assign converged = (liveCount <= LIVE_CNT_W'(1));

    // one send per report, only with a credit in hand
    assign send = report && !outValid && (creditCount != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            creditCount <= OUT_CREDIT_W'(OUT_CREDITS);
        end else begin
            case ({send, outCredit})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= send;
        end
    end

    // equal maxima all reach zero together, reported as a tie
    always_ff @(posedge clk) begin
        if (send) begin
            outIndex <= winnerIdx;
            outValue <= allZero ? '0 : xVec[winnerIdx];
            outTie   <= allZero;
            outIters <= iterCount;
        end
    end

    // controller leaves report on the cycle the pulse goes out
    assign resultSent = outValid;

endmodule

`default_nettype wire

// ==== hw/maxnetController.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxnetController import maxnetPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              bufferFull,
    input  logic              converged,
    input  logic              resultSent,
    output logic              loadStep,
    output logic              startVector,
    output logic              iterate,
    output logic              report,
    output logic [ITER_W-1:0] iterCount
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        START,
        ITERATE,
        REPORT
    } ctrlState;

    ctrlState         state;
    ctrlState         nextState;
    logic [IDX_W-1:0] loadCount;
    logic             lastLoad;

    assign lastLoad = (loadCount == IDX_W'(NUM_NEURONS - 1));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (bufferFull) begin
                    nextState = LOAD;
                end
            end
            LOAD: begin
                if (lastLoad) begin
                    nextState = START;
                end
            end
            START:   nextState = ITERATE;
            ITERATE: begin
                if (converged) begin
                    nextState = REPORT;
                end
            end
            REPORT: begin
                if (resultSent) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // load counter wraps back to 0 after the fourth word
    always_ff @(posedge clk) begin
        if (rst) begin
            loadCount <= '0;
            iterCount <= '0;
        end else begin
            if (loadStep) begin
                loadCount <= loadCount + 1'b1;
            end
            if (startVector) begin
                iterCount <= '0;
            end else if (iterate) begin
                iterCount <= iterCount + 1'b1;
            end
        end
    end

    assign loadStep    = (state == LOAD);
    assign startVector = (state == START);
    assign iterate     = (state == ITERATE) && !converged;
    assign report      = (state == REPORT);

endmodule

`default_nettype wire

// ==== hw/maxnetTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxnetTop import maxnetPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  logic [XLEN-1:0]   inData,
    input  logic              outCredit,
    output logic              inCredit,
    output logic              outValid,
    output logic [IDX_W-1:0]  outIndex,
    output logic [XLEN-1:0]   outValue,
    output logic              outTie,
    output logic [ITER_W-1:0] outIters
);

    wire  [XLEN-1:0]   activations [NUM_NEURONS];
    logic [XLEN-1:0]   xVec [NUM_NEURONS];
    logic              bufferFull;
    logic              loadStep;
    logic              startVector;
    logic              iterate;
    logic              report;
    logic              converged;
    logic              resultSent;
    logic [ITER_W-1:0] iterCount;

    sampleLoader i_sampleLoader (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inData     (inData),
        .loadStep   (loadStep),
        .inCredit   (inCredit),
        .bufferFull (bufferFull),
        .xVec       (xVec)
    );

    maxnetController i_maxnetController (
        .clk         (clk),
        .rst         (rst),
        .bufferFull  (bufferFull),
        .converged   (converged),
        .resultSent  (resultSent),
        .loadStep    (loadStep),
        .startVector (startVector),
        .iterate     (iterate),
        .report      (report),
        .iterCount   (iterCount)
    );

    // one neuron per vector element
    for (genvar n = 0; n < NUM_NEURONS; n++) begin : genNeuron
        maxnetNeuron #(
            .NEURON_INDEX (n)
        ) i_maxnetNeuron (
            .clk         (clk),
            .rst         (rst),
            .startVector (startVector),
            .iterate     (iterate),
            .xOwn        (xVec[n]),
            .activations (activations),
            .activation  (activations[n])
        );
    end

    winnerSelect i_winnerSelect (
        .clk         (clk),
        .rst         (rst),
        .activations (activations),
        .xVec        (xVec),
        .iterCount   (iterCount),
        .report      (report),
        .outCredit   (outCredit),
        .converged   (converged),
        .resultSent  (resultSent),
        .outValid    (outValid),
        .outIndex    (outIndex),
        .outValue    (outValue),
        .outTie      (outTie),
        .outIters    (outIters)
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset released on a rising edge after RESET_CYCLES cycles
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/maxnetChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxnetChecker import maxnetPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  logic [XLEN-1:0]   inData,
    input  logic              inCredit,
    input  logic              outValid,
    input  logic [IDX_W-1:0]  outIndex,
    input  logic [XLEN-1:0]   outValue,
    input  logic              outTie,
    input  logic [ITER_W-1:0] outIters,
    input  int                testId,
    input  logic              testEnd,
    input  logic              runEnd,
    input  logic              expectStall,
    output int                errorCount
);

    // expected result packed as {index, value, tie, iterations}
    localparam int RES_W = IDX_W + XLEN + 1 + ITER_W;

    logic [RES_W-1:0]            expQueue [$];
    logic [NUM_NEURONS*XLEN-1:0] vecWords;
    int                          wordCount;
    int                          srcCredits;
    int                          creditPulses;
    int                          vectorCount;
    int                          compared;
    int                          testResults [8];
    int                          testErrors [8];

    function automatic string testName(input int id);
        case (id)
            1:       return "distinct";
            2:       return "tie";
            3:       return "random";
            4:       return "inCredits";
            5:       return "backPressure";
            6:       return "converged";
            default: return "none";
        endcase
    endfunction

    // Maxnet in software until at most one neuron is left
    function automatic logic [RES_W-1:0] referenceResult(input logic [NUM_NEURONS*XLEN-1:0] x);
        int act [NUM_NEURONS];
        int live;
        int winner;
        int total;
        int step;
        int iters;
        for (int i = 0; i < NUM_NEURONS; i++) begin
            act[i] = int'(x[i*XLEN +: XLEN]);
        end
        iters  = 0;
        live   = NUM_NEURONS;
        winner = 0;
        while (live > 1) begin
            live  = 0;
            total = 0;
            for (int i = 0; i < NUM_NEURONS; i++) begin
                total = total + act[i];
                if (act[i] != 0) begin
                    live   = live + 1;
                    winner = i;
                end
            end
            if (live > 1) begin
                for (int i = 0; i < NUM_NEURONS; i++) begin
                    step   = (total - act[i] + 7) / 8;
                    act[i] = (act[i] > step) ? act[i] - step : 0;
                end
                iters = iters + 1;
            end
        end
        if (live == 0) begin
            return {IDX_W'(0), XLEN'(0), 1'b1, ITER_W'(iters)};
        end
        return {IDX_W'(winner), x[winner*XLEN +: XLEN], 1'b0, ITER_W'(iters)};
    endfunction

    task automatic flagError(input string msg);
        $display("%s", msg);
        errorCount          = errorCount + 1;
        testErrors[testId]  = testErrors[testId] + 1;
    endtask

    task automatic compareField(input string field, input int expValue, input int actValue);
        if (expValue != actValue) begin
            flagError($sformatf("error %s %s: expected %0d actual %0d",
                                testName(testId), field, expValue, actValue));
        end
    endtask

    always @(posedge clk) begin
        logic [RES_W-1:0] expected;
        if (rst) begin
            wordCount    = 0;
            srcCredits   = IN_CREDITS;
            creditPulses = 0;
            vectorCount  = 0;
            compared     = 0;
            errorCount   = 0;
            vecWords     = '0;
            expQueue.delete();
            for (int t = 0; t < 8; t++) begin
                testResults[t] = 0;
                testErrors[t]  = 0;
            end
        end else begin
            if (inValid && srcCredits == 0) begin
                flagError("inValid was raised while the source held no input credit");
            end
            srcCredits   = srcCredits + int'(inCredit) - int'(inValid);
            creditPulses = creditPulses + int'(inCredit);
            if (srcCredits > IN_CREDITS) begin
                flagError("inCredit returned a credit for a word that was never sent");
            end
            // words arrive in element order
            if (inValid) begin
                vecWords[wordCount*XLEN +: XLEN] = inData;
                wordCount = wordCount + 1;
                if (wordCount == NUM_NEURONS) begin
                    expQueue.push_back(referenceResult(vecWords));
                    vectorCount = vectorCount + 1;
                    wordCount   = 0;
                end
            end
            if (outValid && expectStall) begin
                flagError("a result went out while the sink held every credit");
            end
            if (outValid && expQueue.size() == 0) begin
                flagError("a result arrived with no vector outstanding");
            end else if (outValid) begin
                expected = expQueue.pop_front();
                compareField("index", int'(expected[ITER_W+1+XLEN +: IDX_W]), int'(outIndex));
                compareField("value", int'(expected[ITER_W+1 +: XLEN]), int'(outValue));
                compareField("tie", int'(expected[ITER_W]), int'(outTie));
                compareField("iterations", int'(expected[ITER_W-1:0]), int'(outIters));
                compared            = compared + 1;
                testResults[testId] = testResults[testId] + 1;
            end
            if (testEnd) begin
                if (expQueue.size() != 0) begin
                    flagError("results were still missing when the test ended");
                end
                compareField("inCredit pulses", NUM_NEURONS * vectorCount, creditPulses);
                $display("test %s: %0d results, %0d errors",
                         testName(testId), testResults[testId], testErrors[testId]);
            end
            if (runEnd) begin
                $display("%0d results compared, %0d errors", compared, errorCount);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/maxnetTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxnetTb import maxnetPkg::*; ();

    logic              clk;
    logic              rst;
    logic              inValid   = 1'b0;
    logic [XLEN-1:0]   inData    = '0;
    logic              outCredit = 1'b0;
    logic              inCredit;
    logic              outValid;
    logic [IDX_W-1:0]  outIndex;
    logic [XLEN-1:0]   outValue;
    logic              outTie;
    logic [ITER_W-1:0] outIters;

    int              testId       = 1;
    logic            testEnd      = 1'b0;
    logic            runEnd       = 1'b0;
    logic            expectStall  = 1'b0;
    logic            holdCredits  = 1'b0;
    bit              timedOut     = 1'b0;
    int              errorCount;
    int              vectorsSent  = 0;
    int              resultsSeen;
    int              pendingCredits;
    int              creditDelay;
    int              srcCredits;
    logic [31:0]     srcLfsr      = 32'ha984_f46e;
    logic [31:0]     sinkLfsr     = 32'ha984_f46e;
    logic [XLEN-1:0] wordQueue [$];

    clockGen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_clockGen (.clk(clk), .rst(rst));

    maxnetTop i_maxnetTop (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inData    (inData),
        .outCredit (outCredit),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outIndex  (outIndex),
        .outValue  (outValue),
        .outTie    (outTie),
        .outIters  (outIters)
    );

    maxnetChecker i_maxnetChecker (
        .clk (clk), .rst (rst), .inValid (inValid), .inData (inData), .inCredit (inCredit),
        .outValid (outValid), .outIndex (outIndex), .outValue (outValue), .outTie (outTie),
        .outIters (outIters), .testId (testId), .testEnd (testEnd), .runEnd (runEnd),
        .expectStall (expectStall), .errorCount (errorCount)
    );

    // Galois LFSR, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // source: spends one credit per word, regains one per inCredit pulse
    always @(posedge clk) begin
        if (rst) begin
            srcCredits = IN_CREDITS;
            inValid <= 1'b0;
        end else begin
            srcCredits = srcCredits + int'(inCredit);
            if (wordQueue.size() > 0 && srcCredits > 0) begin
                inValid <= 1'b1;
                inData  <= wordQueue.pop_front();
                srcCredits = srcCredits - 1;
            end else begin
                inValid <= 1'b0;
            end
        end
    end

    // sink: one credit back per result, after a random delay of 0 to 3 cycles
    always @(posedge clk) begin
        int         pend;
        logic [1:0] d;
        pend = pendingCredits + int'(outValid);
        if (rst) begin
            pendingCredits <= 0;
            creditDelay    <= 0;
            outCredit      <= 1'b0;
        end else if (pend > 0 && !holdCredits && creditDelay == 0) begin
            outCredit      <= 1'b1;
            pendingCredits <= pend - 1;
            sinkLfsr = lfsrStep(sinkLfsr);
            d[0] = sinkLfsr[0];
            sinkLfsr = lfsrStep(sinkLfsr);
            d[1] = sinkLfsr[0];
            creditDelay    <= int'(d);
        end else begin
            outCredit      <= 1'b0;
            pendingCredits <= pend;
            if (creditDelay > 0) begin
                creditDelay <= creditDelay - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            resultsSeen <= 0;
        end else begin
            resultsSeen <= resultsSeen + int'(outValid);
        end
    end

    task automatic randomVector(output logic [NUM_NEURONS*XLEN-1:0] v);
        for (int b = 0; b < NUM_NEURONS * XLEN; b++) begin
            srcLfsr = lfsrStep(srcLfsr);
            v[b] = srcLfsr[0];
        end
    endtask

    // element 0 sits in the low byte and is sent first
    task automatic sendVector(input logic [NUM_NEURONS*XLEN-1:0] v);
        for (int i = 0; i < NUM_NEURONS; i++) begin
            wordQueue.push_back(v[i*XLEN +: XLEN]);
        end
        vectorsSent = vectorsSent + 1;
    endtask

    task automatic waitResults(input int target);
        int cycles;
        int limit;
        cycles = 0;
        limit  = 300 * (target - resultsSeen) + 200;
        while (!timedOut && resultsSeen < target) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("timeout: result %0d never came out", target);
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (!timedOut && (wordQueue.size() > 0 || pendingCredits > 0 || outCredit)) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 200) begin
                $display("timeout: source or sink did not go idle");
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic finishTest();
        waitResults(vectorsSent);
        waitIdle();
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
        testId  = testId + 1;
    endtask

    initial begin
        logic [NUM_NEURONS*XLEN-1:0] v;
        int                          cycles;
        int                          base;
        cycles = 0;
        @(negedge clk);
        while (!timedOut && rst) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 20) begin
                $display("timeout: reset never released");
                timedOut = 1'b1;
            end
        end
        sendVector({8'd0, 8'd0, 8'd2, 8'd3});
        finishTest();
        sendVector({8'd1, 8'd4, 8'd9, 8'd9});
        finishTest();
        repeat (50) begin
            randomVector(v);
            sendVector(v);
        end
        finishTest();
        repeat (10) begin
            randomVector(v);
            sendVector(v);
        end
        finishTest();
        // two results use up the DUT credits, the third must wait
        holdCredits = 1'b1;
        base        = vectorsSent;
        repeat (4) begin
            randomVector(v);
            sendVector(v);
        end
        waitResults(base + 2);
        expectStall = 1'b1;
        repeat (400) @(negedge clk);
        expectStall = 1'b0;
        holdCredits = 1'b0;
        finishTest();
        sendVector({8'd0, 8'd7, 8'd0, 8'd0});
        finishTest();
        runEnd = 1'b1;
        @(negedge clk);
        if (timedOut || errorCount != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/maxnetPkg.sv
hw/sampleLoader.sv
maxnet/maxnetNeuron.sv
hw/winnerSelect.sv
hw/maxnetController.sv
hw/maxnetTop.sv
sim/clockGen.sv
sim/maxnetChecker.sv
sim/maxnetTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module maxnetTb -Mdir obj_dir
	obj_dir/VmaxnetTb | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir
